// File: mnist_view_pkg.sv
package mnist_view_pkg;

    // ------------------------------------------------------------
    // recognition image geometry
    // ------------------------------------------------------------
    localparam int IMG_SIZE      = 28;  // side of binary image
    localparam int NUM_CLASSES   = 10;  // digits 0..9
    localparam int BIN_THRESHOLD = 30;  // r+g+b below this is dark

    // ------------------------------------------------------------
    // camera side
    // ------------------------------------------------------------
    typedef logic [15:0] pixel_t;       // rgb565, r in [15:11], g in [10:5], b in [4:0]

    // one row of the binary image, bit c = column c
    typedef logic [IMG_SIZE-1:0] img_row_t;

    // row r, bit c = sample r*28+c
    typedef img_row_t [IMG_SIZE-1:0] bin_image_t;

    // classifier result, may be multi-hot
    typedef logic [NUM_CLASSES-1:0] class_t;

    // ------------------------------------------------------------
    // display side
    // ------------------------------------------------------------
    typedef logic [7:0]  channel_t;     // one output colour
    typedef logic [11:0] hcount_t;      // raster x
    typedef logic [10:0] vcount_t;      // raster y

endpackage

// File: display_timing.sv
`timescale 1ns/1ns

module display_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic video_clk,
    input  logic rst_n,
    output logic hs,
    output logic vs,
    output logic de
);
    import mnist_view_pkg::*;

    typedef enum logic [1:0] {H_ACT, H_FP, H_SY, H_BP} h_phase_t;
    typedef enum logic [1:0] {V_ACT, V_FP, V_SY, V_BP} v_phase_t;

    h_phase_t h_state, h_next;
    v_phase_t v_state, v_next;
    hcount_t  h_cnt;                    // pixel within current phase
    hcount_t  h_len;
    vcount_t  v_cnt;                    // line within current phase
    vcount_t  v_len;
    logic     h_last;
    logic     line_end;
    logic     v_last;

    // ------------------------------------------------------------
    // phase lengths and successors
    // ------------------------------------------------------------
    always_comb begin
        case (h_state)
            H_ACT:   begin h_len = hcount_t'(H_ACTIVE); h_next = H_FP;  end
            H_FP:    begin h_len = hcount_t'(H_FRONT);  h_next = H_SY;  end
            H_SY:    begin h_len = hcount_t'(H_SYNC);   h_next = H_BP;  end
            default: begin h_len = hcount_t'(H_BACK);   h_next = H_ACT; end
        endcase
        case (v_state)
            V_ACT:   begin v_len = vcount_t'(V_ACTIVE); v_next = V_FP;  end
            V_FP:    begin v_len = vcount_t'(V_FRONT);  v_next = V_SY;  end
            V_SY:    begin v_len = vcount_t'(V_SYNC);   v_next = V_BP;  end
            default: begin v_len = vcount_t'(V_BACK);   v_next = V_ACT; end
        endcase
    end

    assign h_last   = (h_cnt == h_len - 1'b1);
    assign line_end = h_last && (h_state == H_BP);  // back porch done
    assign v_last   = (v_cnt == v_len - 1'b1);

    // ------------------------------------------------------------
    // raster fsm
    // ------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_state <= H_ACT;           // first line opens in active
            h_cnt   <= '0;
            v_state <= V_ACT;
            v_cnt   <= '0;
            hs      <= 1'b0;
            vs      <= 1'b0;
            de      <= 1'b0;
        end else begin
            if (h_last) begin
                h_state <= h_next;
                h_cnt   <= '0;
            end else begin
                h_cnt   <= h_cnt + 1'b1;
            end
            if (line_end) begin         // vertical steps once per line
                if (v_last) begin
                    v_state <= v_next;
                    v_cnt   <= '0;
                end else begin
                    v_cnt   <= v_cnt + 1'b1;
                end
            end
            de <= (h_state == H_ACT) && (v_state == V_ACT);
            hs <= (h_state == H_SY);    // active high
            vs <= (v_state == V_SY);
        end
    end

    // blanking must cover both syncs
    a_de_not_in_sync: assert property (@(posedge video_clk) disable iff (!rst_n)
        de |-> !(hs || vs));

endmodule

// File: cam_binarizer.sv
`timescale 1ns/1ns

module cam_binarizer #(
    parameter int SAMPLE_SHIFT = 3      // log2 of sampling step
) (
    input  logic                       video_clk,
    input  logic                       rst_n,
    input  logic                       cam_vsync,
    input  logic                       cam_de,
    input  mnist_view_pkg::pixel_t     cam_pixel,
    output mnist_view_pkg::bin_image_t bin_img
);
    import mnist_view_pkg::*;

    localparam int      IMG_PIX  = IMG_SIZE * IMG_SIZE;
    localparam hcount_t COL_MASK = hcount_t'((1 << SAMPLE_SHIFT) - 1);
    localparam vcount_t ROW_MASK = vcount_t'((1 << SAMPLE_SHIFT) - 1);

    hcount_t            cam_col;        // pixel index in line
    vcount_t            cam_row;        // line index in frame
    logic               cam_de_d;
    hcount_t            col_scaled;
    vcount_t            row_scaled;
    logic               sample_en;
    logic [6:0]         px_sum;         // max 31+63+31
    logic               px_dark;
    logic [IMG_PIX-1:0] bin_shr;        // sample shift register

    // ------------------------------------------------------------
    // camera coordinates
    // ------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            cam_col  <= '0;
            cam_row  <= '0;
            cam_de_d <= 1'b0;
        end else begin
            cam_de_d <= cam_de;
            cam_col  <= cam_de ? cam_col + 1'b1 : '0;   // zero during blanking
            if (cam_vsync)
                cam_row <= '0;
            else if (cam_de_d && !cam_de)               // line just ended
                cam_row <= cam_row + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // decimation and threshold
    // ------------------------------------------------------------
    assign col_scaled = cam_col >> SAMPLE_SHIFT;
    assign row_scaled = cam_row >> SAMPLE_SHIFT;

    assign sample_en = cam_de
                    && ((cam_col & COL_MASK) == '0)
                    && ((cam_row & ROW_MASK) == '0)
                    && (col_scaled < IMG_SIZE)
                    && (row_scaled < IMG_SIZE);

    assign px_sum  = 7'(cam_pixel[15:11]) + 7'(cam_pixel[10:5]) + 7'(cam_pixel[4:0]);
    assign px_dark = (px_sum < BIN_THRESHOLD);          // dark stroke = 1

    // new sample at msb, first one ends at bit 0
    always_ff @(posedge video_clk) begin
        if (sample_en)
            bin_shr <= {px_dark, bin_shr[IMG_PIX-1:1]};
    end

    // hold image stable outside vsync
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n)
            bin_img <= '0;
        else if (cam_vsync)
            bin_img <= bin_shr;
    end

    // classifier relies on a frozen image between frames
    a_img_only_in_vsync: assert property (@(posedge video_clk) disable iff (!rst_n)
        $changed(bin_img) |-> $past(cam_vsync));

endmodule

// File: overlay_compositor.sv
`timescale 1ns/1ns

module overlay_compositor #(
    parameter int BIN_SHIFT   = 4,      // log2 of binary cell size
    parameter int BIN_X       = 50,     // in cells
    parameter int BIN_Y       = 1,
    parameter int CLASS_SHIFT = 5,      // log2 of class block size
    parameter int CLASS_X     = 1,      // in blocks
    parameter int CLASS_Y     = 18
) (
    input  logic                       video_clk,
    input  logic                       rst_n,
    input  logic                       hs,
    input  logic                       vs,
    input  logic                       de,
    input  mnist_view_pkg::bin_image_t bin_img,
    input  mnist_view_pkg::class_t     class_bits,
    output mnist_view_pkg::channel_t   rgb_r,
    output mnist_view_pkg::channel_t   rgb_g,
    output mnist_view_pkg::channel_t   rgb_b,
    output logic                       out_hs,
    output logic                       out_vs,
    output logic                       out_de
);
    import mnist_view_pkg::*;

    localparam int IDX_W = $clog2(IMG_SIZE);
    localparam int CLS_W = $clog2(NUM_CLASSES);

    hcount_t          x;                // column while de high
    vcount_t          y;                // active line in frame
    logic             de_d;
    hcount_t          x_bin;
    vcount_t          y_bin;
    hcount_t          x_cls;
    vcount_t          y_cls;
    logic             in_bin;
    logic             in_cls;
    logic [IDX_W-1:0] bin_row;
    logic [IDX_W-1:0] bin_col;
    logic [CLS_W-1:0] cls_idx;
    logic             bin_bit;
    logic             cls_bit;

    // ------------------------------------------------------------
    // raster position
    // ------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            x    <= '0;
            y    <= '0;
            de_d <= 1'b0;
        end else begin
            de_d <= de;
            x    <= de ? x + 1'b1 : '0;
            if (vs)
                y <= '0;
            else if (de_d && !de)       // end of active line
                y <= y + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // region tests and cell lookup
    // ------------------------------------------------------------
    assign x_bin = x >> BIN_SHIFT;
    assign y_bin = y >> BIN_SHIFT;
    assign x_cls = x >> CLASS_SHIFT;
    assign y_cls = y >> CLASS_SHIFT;

    assign in_bin = (x_bin >= BIN_X) && (x_bin < BIN_X + IMG_SIZE)
                 && (y_bin >= BIN_Y) && (y_bin < BIN_Y + IMG_SIZE);
    assign in_cls = (x_cls >= CLASS_X) && (x_cls < CLASS_X + NUM_CLASSES)
                 && (y_cls == CLASS_Y);                 // single row of blocks

    assign bin_row = IDX_W'(y_bin - vcount_t'(BIN_Y));
    assign bin_col = IDX_W'(x_bin - hcount_t'(BIN_X));
    assign cls_idx = CLS_W'(x_cls - hcount_t'(CLASS_X));

    assign bin_bit = bin_img[bin_row][bin_col];         // only read inside region
    assign cls_bit = class_bits[cls_idx];

    // ------------------------------------------------------------
    // colour select, one stage with syncs
    // ------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_hs <= 1'b0;
            out_vs <= 1'b0;
            out_de <= 1'b0;
            rgb_r  <= '0;
            rgb_g  <= '0;
            rgb_b  <= '0;
        end else begin
            out_hs <= hs;
            out_vs <= vs;
            out_de <= de;
            if (!de) begin              // black in blanking
                rgb_r <= '0;
                rgb_g <= '0;
                rgb_b <= '0;
            end else if (in_bin) begin
                rgb_r <= {8{bin_bit}};
                rgb_g <= {8{bin_bit}};
                rgb_b <= {8{bin_bit}};
            end else if (in_cls) begin
                rgb_r <= {8{cls_bit}};
                rgb_g <= {8{cls_bit}};
                rgb_b <= {8{cls_bit}};
            end else begin              // gradient background
                rgb_r <= channel_t'(x);
                rgb_g <= channel_t'(y);
                rgb_b <= 8'hFF;
            end
        end
    end

    a_black_in_blank: assert property (@(posedge video_clk) disable iff (!rst_n)
        !out_de |-> (rgb_r == '0) && (rgb_g == '0) && (rgb_b == '0));

endmodule

// File: mnist_view_top.sv
`timescale 1ns/1ns

module mnist_view_top #(
    parameter int H_ACTIVE     = 1280,
    parameter int H_FRONT      = 110,
    parameter int H_SYNC       = 40,
    parameter int H_BACK       = 220,
    parameter int V_ACTIVE     = 720,
    parameter int V_FRONT      = 5,
    parameter int V_SYNC       = 5,
    parameter int V_BACK       = 20,
    parameter int SAMPLE_SHIFT = 3,
    parameter int BIN_SHIFT    = 4,
    parameter int BIN_X        = 50,
    parameter int BIN_Y        = 1,
    parameter int CLASS_SHIFT  = 5,
    parameter int CLASS_X      = 1,
    parameter int CLASS_Y      = 18
) (
    input  logic                       video_clk,
    input  logic                       rst_n,
    input  logic                       cam_vsync,
    input  logic                       cam_de,
    input  mnist_view_pkg::pixel_t     cam_pixel,
    input  mnist_view_pkg::class_t     class_bits,  // from external classifier
    output mnist_view_pkg::bin_image_t bin_img,     // to external classifier
    output mnist_view_pkg::channel_t   rgb_r,
    output mnist_view_pkg::channel_t   rgb_g,
    output mnist_view_pkg::channel_t   rgb_b,
    output logic                       out_hs,
    output logic                       out_vs,
    output logic                       out_de
);

    logic hs;                           // raw raster timing
    logic vs;
    logic de;

    // ------------------------------------------------------------
    // display timing
    // ------------------------------------------------------------
    display_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs        (hs),
        .vs        (vs),
        .de        (de)
    );

    // ------------------------------------------------------------
    // camera to 28x28 binary image
    // ------------------------------------------------------------
    cam_binarizer #(
        .SAMPLE_SHIFT (SAMPLE_SHIFT)
    ) u_binarizer (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_de    (cam_de),
        .cam_pixel (cam_pixel),
        .bin_img   (bin_img)
    );

    overlay_compositor #(
        .BIN_SHIFT   (BIN_SHIFT),   .BIN_X   (BIN_X),   .BIN_Y   (BIN_Y),
        .CLASS_SHIFT (CLASS_SHIFT), .CLASS_X (CLASS_X), .CLASS_Y (CLASS_Y)
    ) u_overlay (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .hs         (hs),
        .vs         (vs),
        .de         (de),
        .bin_img    (bin_img),
        .class_bits (class_bits),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de)
    );

endmodule

// File: tb_mnist_view.sv
`timescale 1ns/1ns

module tb_mnist_view;
    import mnist_view_pkg::*;

    // ------------------------------------------------------------
    // reduced raster and overlay geometry
    // ------------------------------------------------------------
    localparam int H_ACTIVE     = 48;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 4;
    localparam int V_ACTIVE     = 36;
    localparam int V_FRONT      = 2;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int SAMPLE_SHIFT = 0;    // every camera pixel sampled
    localparam int BIN_SHIFT    = 0;    // one raster pixel per cell
    localparam int BIN_X        = 2;
    localparam int BIN_Y        = 1;
    localparam int CLASS_SHIFT  = 1;    // 2x2 class blocks
    localparam int CLASS_X      = 2;
    localparam int CLASS_Y      = 15;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYC       = 8;
    localparam int NUM_FRAMES      = 2;
    localparam int WORDS_PER_FRAME = IMG_SIZE + 1;      // class word + row masks
    localparam int LINE_GAP        = 2;                 // idle cycles between lines
    localparam int VSYNC_CYC       = 4;
    localparam int CAM_FRAME_CYC   = IMG_SIZE * (IMG_SIZE + LINE_GAP) + VSYNC_CYC;
    localparam int H_TOTAL         = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL         = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int DISP_FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS     = 2 * NUM_FRAMES * (CAM_FRAME_CYC + 2 * DISP_FRAME_CYC)
                                   * CLK_PERIOD;

    logic       video_clk;
    logic       rst_n;
    logic       cam_vsync;
    logic       cam_de;
    pixel_t     cam_pixel;
    class_t     class_bits;
    bin_image_t bin_img;
    channel_t   rgb_r;
    channel_t   rgb_g;
    channel_t   rgb_b;
    logic       out_hs;
    logic       out_vs;
    logic       out_de;

    logic [IMG_SIZE-1:0] pat_mem [0:NUM_FRAMES*WORDS_PER_FRAME-1];
    img_row_t            cur_rows [IMG_SIZE];   // expected image of current frame
    class_t              cur_class;
    integer              seed         = 42821;
    int                  err_count    = 0;
    int                  fail_count   = 0;
    logic                pix_check_on = 1'b0;   // pixel compare window
    int                  pix_count    = 0;
    int                  total_pix    = 0;
    int                  x_pos        = 0;      // tracked from out_de
    int                  y_pos        = 0;      // tracked from out_vs and line ends
    int                  line_cnt     = 0;
    int                  hs_count     = 0;      // out_hs pulses in checked frame
    int                  hs_width     = 0;
    int                  since_de     = 0;      // blank cycles since last out_de
    logic                prev_de      = 1'b0;
    logic                prev_vs      = 1'b0;
    logic                prev_hs      = 1'b0;

    mnist_view_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .SAMPLE_SHIFT (SAMPLE_SHIFT),
        .BIN_SHIFT    (BIN_SHIFT),   .BIN_X   (BIN_X),   .BIN_Y   (BIN_Y),
        .CLASS_SHIFT  (CLASS_SHIFT), .CLASS_X (CLASS_X), .CLASS_Y (CLASS_Y)
    ) uut (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .cam_vsync  (cam_vsync),
        .cam_de     (cam_de),
        .cam_pixel  (cam_pixel),
        .class_bits (class_bits),
        .bin_img    (bin_img),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de)
    );

    initial begin
        video_clk = 1'b0;
        forever #(CLK_PERIOD / 2) video_clk = ~video_clk;
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_row(input img_row_t got, input img_row_t exp, input string name);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_rgb(input channel_t got, input channel_t exp, input string name);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_idle_outputs();
        if (out_de !== 1'b0 || out_hs !== 1'b0 || out_vs !== 1'b0) begin
            $display("Failure at %0t ns: display outputs not idle around reset (de=%b hs=%b vs=%b)",
                     $time, out_de, out_hs, out_vs);
            fail_count++;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    // dark pixel keeps r+g+b under 30 and light one reaches at least 30
    task automatic random_pixel(input logic dark, output pixel_t px);
        logic [31:0] rnd;
        logic [4:0]  r;
        logic [5:0]  g;
        logic [4:0]  b;
        rnd = $random(seed);
        if (dark) begin
            r = 5'(rnd[7:0] % 10);
            g = 6'(rnd[15:8] % 10);
            b = 5'(rnd[23:16] % 10);
        end else begin
            r = rnd[4:0];
            g = 6'(30 + rnd[15:8] % 34);                // green alone gets past 30
            b = rnd[20:16];
        end
        px = {r, g, b};
    endtask

    task automatic send_frame(input int frame);
        pixel_t              px;
        logic [IMG_SIZE-1:0] mask;
        for (int r = 0; r < IMG_SIZE; r++) begin
            mask = pat_mem[frame * WORDS_PER_FRAME + 1 + r];
            for (int c = 0; c < IMG_SIZE; c++) begin
                random_pixel(mask[c], px);
                @(posedge video_clk);
                cam_de    <= 1'b1;
                cam_pixel <= px;
            end
            repeat (LINE_GAP) begin                     // horizontal blank
                @(posedge video_clk);
                cam_de    <= 1'b0;
                cam_pixel <= '0;
            end
        end
        repeat (VSYNC_CYC) begin
            @(posedge video_clk);
            cam_vsync <= 1'b1;                          // latches the image
        end
        @(posedge video_clk);
        cam_vsync <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // display model
    // ------------------------------------------------------------
    task automatic check_pixel(input int px, input int py);
        channel_t exp_r;
        channel_t exp_g;
        channel_t exp_b;
        int       cx;
        int       cy;
        logic     lit;
        exp_r = channel_t'(px);                         // gradient background
        exp_g = channel_t'(py);
        exp_b = 8'hFF;
        cx = px >> BIN_SHIFT;
        cy = py >> BIN_SHIFT;
        if (cx >= BIN_X && cx < BIN_X + IMG_SIZE && cy >= BIN_Y && cy < BIN_Y + IMG_SIZE) begin
            lit   = cur_rows[cy - BIN_Y][cx - BIN_X];
            exp_r = {8{lit}};
            exp_g = {8{lit}};
            exp_b = {8{lit}};
        end else begin
            cx = px >> CLASS_SHIFT;
            cy = py >> CLASS_SHIFT;
            if (cx >= CLASS_X && cx < CLASS_X + NUM_CLASSES && cy == CLASS_Y) begin
                lit   = cur_class[cx - CLASS_X];
                exp_r = {8{lit}};
                exp_g = {8{lit}};
                exp_b = {8{lit}};
            end
        end
        check_rgb(rgb_r, exp_r, $sformatf("rgb_r(%0d,%0d)", px, py));
        check_rgb(rgb_g, exp_g, $sformatf("rgb_g(%0d,%0d)", px, py));
        check_rgb(rgb_b, exp_b, $sformatf("rgb_b(%0d,%0d)", px, py));
        pix_count++;
    endtask

    // raster monitor on the falling edge where outputs are stable
    always @(negedge video_clk) begin
        if (rst_n) begin
            if (out_vs && !prev_vs) begin               // frame boundary
                if (line_cnt != V_ACTIVE) begin
                    $display("Failure at %0t ns: frame had %0d active lines, expected %0d",
                             $time, line_cnt, V_ACTIVE);
                    fail_count++;
                end
                line_cnt = 0;
                y_pos    = 0;
            end
            if (out_hs) begin
                if (!prev_hs) begin                     // sync follows the front porch
                    hs_count++;
                    if (since_de <= H_TOTAL && since_de != H_FRONT) begin
                        $display("Failure at %0t ns: out_hs rose %0d cycles after out_de, expected %0d",
                                 $time, since_de, H_FRONT);
                        fail_count++;
                    end
                end
                hs_width++;
            end else if (prev_hs) begin
                if (hs_width != H_SYNC) begin
                    $display("Failure at %0t ns: out_hs pulse lasted %0d cycles, expected %0d",
                             $time, hs_width, H_SYNC);
                    fail_count++;
                end
                hs_width = 0;
            end
            if (out_de)
                since_de = 0;
            else
                since_de++;
            if (out_de) begin
                if (pix_check_on)
                    check_pixel(x_pos, y_pos);
                x_pos++;
            end else if (prev_de) begin                 // line just ended
                if (x_pos != H_ACTIVE) begin
                    $display("Failure at %0t ns: line had %0d active pixels, expected %0d",
                             $time, x_pos, H_ACTIVE);
                    fail_count++;
                end
                x_pos = 0;
                line_cnt++;
                y_pos++;
            end
            prev_de = out_de;
            prev_vs = out_vs;
            prev_hs = out_hs;
        end
    end

    // one full frame between two out_vs pulses
    task automatic check_display_frame();
        @(posedge out_vs);
        pix_count    = 0;
        hs_count     = 0;
        pix_check_on = 1'b1;
        @(posedge out_vs);
        pix_check_on = 1'b0;
        total_pix   += pix_count;
        if (pix_count != H_ACTIVE * V_ACTIVE) begin
            $display("Failure at %0t ns: checked %0d pixels in a display frame, expected %0d",
                     $time, pix_count, H_ACTIVE * V_ACTIVE);
            fail_count++;
        end
        if (hs_count != V_TOTAL) begin
            $display("Failure at %0t ns: display frame had %0d out_hs pulses, expected %0d",
                     $time, hs_count, V_TOTAL);
            fail_count++;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        cam_vsync  = 1'b0;
        cam_de     = 1'b0;
        cam_pixel  = '0;
        class_bits = '0;
        cur_class  = '0;
        $readmemh("mnist_view_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[0])) begin
            $display("Failure: pattern file mnist_view_patterns.txt could not be read");
            fail_count++;
        end
        repeat (RESET_CYC - 1) @(posedge video_clk);
        @(negedge video_clk);
        check_idle_outputs();
        @(posedge video_clk);
        rst_n <= 1'b1;
        @(negedge video_clk);
        check_idle_outputs();                           // before first display line

        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int r = 0; r < IMG_SIZE; r++)
                cur_rows[r] = pat_mem[f * WORDS_PER_FRAME + 1 + r];
            send_frame(f);
            repeat (2) @(posedge video_clk);
            @(negedge video_clk);
            for (int r = 0; r < IMG_SIZE; r++)
                check_row(bin_img[r], cur_rows[r], $sformatf("bin_img[%0d]", r));
            @(posedge video_clk);
            class_bits <= pat_mem[f * WORDS_PER_FRAME][NUM_CLASSES-1:0];
            cur_class   = pat_mem[f * WORDS_PER_FRAME][NUM_CLASSES-1:0];
            check_display_frame();
        end

        $display("Summary: %0d value errors, %0d other failures, %0d pixels checked",
                 err_count, fail_count, total_pix);
        if (err_count == 0 && fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns, the run did not complete", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: mnist_view_patterns.txt
// per frame: one class word (bit n = digit n), then 28 row masks (rows 0..27)
// row mask bit c = column c, a set bit is a dark camera pixel
// frame 0: digit 7, class 7
0000080
0000000
0000000
0000000
0000000
03FFFC0
03FFFC0
03FFFC0
03C0000
03C0000
01E0000
01E0000
00F0000
00F0000
0078000
0078000
003C000
003C000
001E000
001E000
000F000
000F000
0007800
0007800
0000000
0000000
0000000
0000000
0000000
// frame 1: digit 0, classes 0 and 9
0000201
0000000
0000000
0000000
0000000
003FC00
00FFF00
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
01E0780
00FFF00
003FC00
0000000
0000000
0000000
0000000
0000000

// File: mnist_view.f
mnist_view_pkg.sv
display_timing.sv
cam_binarizer.sv
overlay_compositor.sv
mnist_view_top.sv
tb_mnist_view.sv
